// ==== verilog/display_pkg.sv ====
package display_pkg;

    // Packed RGB565, red 15:11, green 10:5, blue 4:0
    typedef logic [15:0] pix565_t;

    // Output pixel, red in the top byte
    typedef logic [23:0] rgb888_t;

    // 4x down/upscale between camera and frame store
    localparam int SCALE_SHIFT = 2;

    // Counters to rgb_o: address, read data, unpack/mask, mux
    localparam int PIPE_DELAY = 4;

    // Channel fed to the threshold mask
    typedef enum logic [1:0] {
        CH_RED,
        CH_GREEN,
        CH_BLUE
    } channel_sel_e;

    // Output view
    typedef enum logic [1:0] {
        VIEW_CAMERA,
        VIEW_MASK,
        VIEW_OVERLAY
    } view_mode_e;

    localparam rgb888_t COLOR_CROSS = 24'hFF_FF_00; // Yellow crosshair
    localparam rgb888_t COLOR_GOOD  = 24'h00_FF_00; // Judgment passed
    localparam rgb888_t COLOR_BAD   = 24'hFF_00_00; // Judgment failed

    // Judgment border width in pixels
    localparam int BORDER = 2;

endpackage

// ==== verilog/video_timing.sv ====
`timescale 1ns/1ps

module video_timing #(
    parameter int H_ACTIVE = 1280,
    parameter int H_FRONT  = 110,
    parameter int H_SYNC   = 40,
    parameter int H_BACK   = 220,
    parameter int V_ACTIVE = 720,
    parameter int V_FRONT  = 5,
    parameter int V_SYNC   = 5,
    parameter int V_BACK   = 20
) (
    input  logic        clk_pixel,
    input  logic        recent_reset,
    output logic [10:0] hcount_o,
    output logic [10:0] vcount_o,
    output logic        hsync_o,
    output logic        vsync_o,
    output logic        active_o,
    output logic        new_frame_o
);

    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    // Sync windows follow the front porch
    localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
    localparam int H_SYNC_END   = H_SYNC_START + H_SYNC;
    localparam int V_SYNC_START = V_ACTIVE + V_FRONT;
    localparam int V_SYNC_END   = V_SYNC_START + V_SYNC;

    logic line_end;
    logic frame_end;

    assign line_end  = (hcount_o == H_TOTAL - 1);
    assign frame_end = (vcount_o == V_TOTAL - 1);

    // Free-running raster scan
    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            hcount_o <= '0;
            vcount_o <= '0;
        end else if (line_end) begin
            hcount_o <= '0;
            if (frame_end) begin
                vcount_o <= '0;
            end else begin
                vcount_o <= vcount_o + 11'd1;
            end
        end else begin
            hcount_o <= hcount_o + 11'd1;
        end
    end

    // Decoded straight from the counters, so aligned with them
    assign hsync_o = (hcount_o >= H_SYNC_START) && (hcount_o < H_SYNC_END);
    assign vsync_o = (vcount_o >= V_SYNC_START) && (vcount_o < V_SYNC_END); // Whole lines

    assign active_o = (hcount_o < H_ACTIVE) && (vcount_o < V_ACTIVE);

    // One cycle at the top-left corner
    assign new_frame_o = (hcount_o == '0) && (vcount_o == '0);

endmodule

// ==== verilog/frame_store.sv ====
`timescale 1ns/1ps

module frame_store import display_pkg::*; #(
    parameter int H_ACTIVE = 1280,
    parameter int V_ACTIVE = 720
) (
    input  logic        clk_pixel,
    input  logic        recent_reset,
    // Camera write port, four-phase req/ack
    input  logic        wr_req_i,
    input  logic [10:0] wr_x_i,
    input  logic [10:0] wr_y_i,
    input  pix565_t     wr_data_i,
    output logic        wr_ack_o,
    // Display read port
    input  logic [10:0] rd_x_i,
    input  logic [10:0] rd_y_i,
    output pix565_t     rd_data_o
);

    // Quarter-resolution store
    localparam int FS_W     = H_ACTIVE >> SCALE_SHIFT;
    localparam int FS_H     = V_ACTIVE >> SCALE_SHIFT;
    localparam int FS_DEPTH = FS_W * FS_H;
    localparam int AW       = (FS_DEPTH > 1) ? $clog2(FS_DEPTH) : 1;

    pix565_t mem [FS_DEPTH];

    logic          wr_take;    // Request seen, not yet acked
    logic          wr_keep;    // Pixel survives the downscale
    logic [AW-1:0] wr_addr;

    logic [AW-1:0] rd_addr;
    logic          rd_in_area;

    assign wr_take = wr_req_i && !wr_ack_o;

    // Keep only the top-left pixel of each 4x4 block inside the active area
    assign wr_keep = (wr_x_i[SCALE_SHIFT-1:0] == '0)
                  && (wr_y_i[SCALE_SHIFT-1:0] == '0)
                  && (wr_x_i < H_ACTIVE)
                  && (wr_y_i < V_ACTIVE);

    assign wr_addr = AW'((wr_x_i >> SCALE_SHIFT) + (wr_y_i >> SCALE_SHIFT) * FS_W);

    // Ack rises one cycle after req, drops once req is released
    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            wr_ack_o <= 1'b0;
        end else if (wr_take) begin
            wr_ack_o <= 1'b1;
        end else if (!wr_req_i) begin
            wr_ack_o <= 1'b0;
        end
    end

    // Filtered writes are acked but never reach the memory
    always_ff @(posedge clk_pixel) begin
        if (wr_take && wr_keep) begin
            mem[wr_addr] <= wr_data_i;
        end
    end

    // Stage 1, upscaled address from the raster counters
    always_ff @(posedge clk_pixel) begin
        rd_addr    <= AW'((rd_x_i >> SCALE_SHIFT) + (rd_y_i >> SCALE_SHIFT) * FS_W);
        rd_in_area <= (rd_x_i < H_ACTIVE) && (rd_y_i < V_ACTIVE);
    end

    // Stage 2, registered data
    // A write to the same address in this cycle still returns the old pixel
    always_ff @(posedge clk_pixel) begin
        if (rd_in_area) begin
            rd_data_o <= mem[rd_addr];
        end else begin
            rd_data_o <= '0;           // Blanking reads show black
        end
    end

endmodule

// ==== verilog/pixel_mask.sv ====
`timescale 1ns/1ps

module pixel_mask import display_pkg::*; (
    input  logic         clk_pixel,
    input  pix565_t      pix_i,
    input  channel_sel_e chan_sel_i,
    input  logic [7:0]   thresh_lo_i,
    input  logic [7:0]   thresh_hi_i,
    output rgb888_t      rgb_o,
    output logic         mask_o
);

    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
    logic [7:0] channel;
    logic       in_range;

    // Fields go to the top bits, low bits zero-filled
    assign red   = {pix_i[15:11], 3'b000};
    assign green = {pix_i[10:5], 2'b00};
    assign blue  = {pix_i[4:0], 3'b000};

    always_comb begin
        case (chan_sel_i)
            CH_RED:   channel = red;
            CH_GREEN: channel = green;
            CH_BLUE:  channel = blue;
            default:  channel = 8'h00;    // Unused code never passes
        endcase
    end

    // Window is open at the bottom, closed at the top
    assign in_range = (channel > thresh_lo_i) && (channel <= thresh_hi_i);

    always_ff @(posedge clk_pixel) begin
        rgb_o  <= {red, green, blue};
        mask_o <= in_range;
    end

endmodule

// ==== verilog/overlay_mux.sv ====
`timescale 1ns/1ps

module overlay_mux import display_pkg::*; #(
    parameter int H_ACTIVE = 1280,
    parameter int V_ACTIVE = 720
) (
    input  logic        clk_pixel,
    input  logic [10:0] hcount_i,     // Aligned with rgb_i and mask_i
    input  logic [10:0] vcount_i,
    input  rgb888_t     rgb_i,
    input  logic        mask_i,
    input  view_mode_e  view_i,
    input  logic [10:0] marker_x_i,
    input  logic [10:0] marker_y_i,
    input  logic        judgment_ok_i,
    output rgb888_t     rgb_o
);

    logic    in_active;
    logic    on_border;
    logic    on_cross;
    rgb888_t mask_pixel;
    rgb888_t overlay_pixel;
    rgb888_t view_pixel;

    assign in_active = (hcount_i < H_ACTIVE) && (vcount_i < V_ACTIVE);

    // Frame of BORDER pixels along each edge
    assign on_border = (hcount_i < BORDER) || (hcount_i >= H_ACTIVE - BORDER)
                    || (vcount_i < BORDER) || (vcount_i >= V_ACTIVE - BORDER);

    assign on_cross = (hcount_i == marker_x_i) || (vcount_i == marker_y_i);

    assign mask_pixel = mask_i ? 24'hFF_FF_FF : 24'h00_00_00;

    // Border wins over the crosshair
    always_comb begin
        if (on_border) begin
            overlay_pixel = judgment_ok_i ? COLOR_GOOD : COLOR_BAD;
        end else if (on_cross) begin
            overlay_pixel = COLOR_CROSS;
        end else begin
            overlay_pixel = rgb_i;
        end
    end

    always_comb begin
        case (view_i)
            VIEW_MASK:    view_pixel = mask_pixel;
            VIEW_OVERLAY: view_pixel = overlay_pixel;
            default:      view_pixel = rgb_i;      // Camera view
        endcase
    end

    always_ff @(posedge clk_pixel) begin
        if (in_active) begin
            rgb_o <= view_pixel;
        end else begin
            rgb_o <= '0;
        end
    end

endmodule

// ==== verilog/display_top.sv ====
`timescale 1ns/1ps

module display_top import display_pkg::*; #(
    parameter int H_ACTIVE = 1280,
    parameter int H_FRONT  = 110,
    parameter int H_SYNC   = 40,
    parameter int H_BACK   = 220,
    parameter int V_ACTIVE = 720,
    parameter int V_FRONT  = 5,
    parameter int V_SYNC   = 5,
    parameter int V_BACK   = 20
) (
    input  logic         clk_pixel,
    input  logic         recent_reset,
    input  logic         wr_req_i,
    input  logic [10:0]  wr_x_i,
    input  logic [10:0]  wr_y_i,
    input  pix565_t      wr_data_i,
    input  channel_sel_e chan_sel_i,
    input  logic [7:0]   thresh_lo_i,
    input  logic [7:0]   thresh_hi_i,
    input  view_mode_e   view_i,
    input  logic [10:0]  marker_x_i,
    input  logic [10:0]  marker_y_i,
    input  logic         judgment_ok_i,
    output logic         wr_ack_o,
    output logic         hsync_o,
    output logic         vsync_o,
    output logic         de_o,
    output rgb888_t      rgb_o
);

    logic [10:0] hcount;
    logic [10:0] vcount;
    logic        hsync;
    logic        vsync;
    logic        active;
    logic        new_frame;

    pix565_t     fb_pixel;
    rgb888_t     cam_rgb;
    logic        mask;

    // Display settings, held for a whole frame
    channel_sel_e chan_sel;
    logic [7:0]   thresh_lo;
    logic [7:0]   thresh_hi;
    view_mode_e   view;
    logic [10:0]  marker_x;
    logic [10:0]  marker_y;
    logic         judgment_ok;

    logic [PIPE_DELAY-1:0] hsync_pipe;
    logic [PIPE_DELAY-1:0] vsync_pipe;
    logic [PIPE_DELAY-1:0] de_pipe;
    logic [10:0]           hcount_pipe [PIPE_DELAY-1];  // Counters for the mux stage
    logic [10:0]           vcount_pipe [PIPE_DELAY-1];

    video_timing #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) u_timing (
        .clk_pixel(clk_pixel),
        .recent_reset(recent_reset),
        .hcount_o(hcount),
        .vcount_o(vcount),
        .hsync_o(hsync),
        .vsync_o(vsync),
        .active_o(active),
        .new_frame_o(new_frame)
    );

    // Settings change only at the top of a frame, no tearing
    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            chan_sel    <= CH_RED;
            thresh_lo   <= '0;
            thresh_hi   <= '0;
            view        <= VIEW_CAMERA;
            marker_x    <= '0;
            marker_y    <= '0;
            judgment_ok <= 1'b0;
        end else if (new_frame) begin
            chan_sel    <= chan_sel_i;
            thresh_lo   <= thresh_lo_i;
            thresh_hi   <= thresh_hi_i;
            view        <= view_i;
            marker_x    <= marker_x_i;
            marker_y    <= marker_y_i;
            judgment_ok <= judgment_ok_i;
        end
    end

    frame_store #(
        .H_ACTIVE(H_ACTIVE),
        .V_ACTIVE(V_ACTIVE)
    ) u_store (
        .clk_pixel(clk_pixel),
        .recent_reset(recent_reset),
        .wr_req_i(wr_req_i),
        .wr_x_i(wr_x_i),
        .wr_y_i(wr_y_i),
        .wr_data_i(wr_data_i),
        .wr_ack_o(wr_ack_o),
        .rd_x_i(hcount),
        .rd_y_i(vcount),
        .rd_data_o(fb_pixel)
    );

    pixel_mask u_mask (
        .clk_pixel(clk_pixel),
        .pix_i(fb_pixel),
        .chan_sel_i(chan_sel),
        .thresh_lo_i(thresh_lo),
        .thresh_hi_i(thresh_hi),
        .rgb_o(cam_rgb),
        .mask_o(mask)
    );

    overlay_mux #(
        .H_ACTIVE(H_ACTIVE),
        .V_ACTIVE(V_ACTIVE)
    ) u_overlay (
        .clk_pixel(clk_pixel),
        .hcount_i(hcount_pipe[PIPE_DELAY-2]),
        .vcount_i(vcount_pipe[PIPE_DELAY-2]),
        .rgb_i(cam_rgb),
        .mask_i(mask),
        .view_i(view),
        .marker_x_i(marker_x),
        .marker_y_i(marker_y),
        .judgment_ok_i(judgment_ok),
        .rgb_o(rgb_o)
    );

    // Sync and data-enable follow the pixel through all four stages
    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            hsync_pipe <= '0;
            vsync_pipe <= '0;
            de_pipe    <= '0;
        end else begin
            hsync_pipe <= {hsync_pipe[PIPE_DELAY-2:0], hsync};
            vsync_pipe <= {vsync_pipe[PIPE_DELAY-2:0], vsync};
            de_pipe    <= {de_pipe[PIPE_DELAY-2:0], active};
        end
    end

    always_ff @(posedge clk_pixel) begin
        hcount_pipe[0] <= hcount;
        vcount_pipe[0] <= vcount;
        for (int i = 1; i < PIPE_DELAY - 1; i++) begin
            hcount_pipe[i] <= hcount_pipe[i-1];
            vcount_pipe[i] <= vcount_pipe[i-1];
        end
    end

    assign hsync_o = hsync_pipe[PIPE_DELAY-1];
    assign vsync_o = vsync_pipe[PIPE_DELAY-1];
    assign de_o    = de_pipe[PIPE_DELAY-1];

endmodule

// ==== verif/tb_vectors.svh ====
    // Each column is an array indexed by test number
    // Columns hold the write position and its expected downscale keep flag, then the display settings
    localparam int N_TESTS = 12;

    logic [10:0]  tab_x    [N_TESTS] = '{4, 5, 8, 40, 0, 12, 28, 8, 16, 20, 2, 24};
    logic [10:0]  tab_y    [N_TESTS] = '{4, 4, 3, 0, 12, 8, 0, 8, 4, 12, 2, 16};
    logic         tab_keep [N_TESTS] = '{1, 0, 0, 0, 1, 1, 1, 1, 1, 1, 0, 0};
    channel_sel_e tab_ch   [N_TESTS] = '{CH_RED, CH_RED, CH_RED, CH_RED, CH_RED, CH_GREEN,
                                         CH_BLUE, CH_RED, CH_GREEN, CH_BLUE, CH_RED, CH_RED};
    logic [7:0]   tab_lo   [N_TESTS] = '{'h00, 'h00, 'h00, 'h00, 'h40, 'h20,
                                         'h00, 'h78, 'h00, 'h00, 'h00, 'h00};
    logic [7:0]   tab_hi   [N_TESTS] = '{'hFF, 'hFF, 'hFF, 'hFF, 'hC0, 'h80,
                                         'hF8, 'h80, 'hFF, 'hFF, 'hFF, 'hFF};
    view_mode_e   tab_view [N_TESTS] = '{VIEW_CAMERA, VIEW_CAMERA, VIEW_CAMERA, VIEW_CAMERA,
                                         VIEW_MASK, VIEW_MASK, VIEW_MASK, VIEW_MASK,
                                         VIEW_OVERLAY, VIEW_OVERLAY, VIEW_OVERLAY, VIEW_CAMERA};
    logic [10:0]  tab_mx   [N_TESTS] = '{0, 0, 0, 0, 0, 0, 0, 0, 10, 20, 15, 0};
    logic [10:0]  tab_my   [N_TESTS] = '{0, 0, 0, 0, 0, 0, 0, 0, 7, 13, 8, 0};
    logic         tab_ok   [N_TESTS] = '{0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 1, 0};

// ==== verif/tb_display_top.sv ====
`timescale 1ns/1ps

module tb_display_top import display_pkg::*; ();

    localparam int H_ACTIVE = 32;
    localparam int H_SYNC   = 2;
    localparam int H_TOTAL  = H_ACTIVE + 6;          // Porches and sync of 2 each
    localparam int V_ACTIVE = 16;
    localparam int V_SYNC   = 2;
    localparam int FRAME    = H_TOTAL * (V_ACTIVE + 6);
    localparam int FS_W     = H_ACTIVE / 4;          // Blocks per stored row

    logic         clk_pixel = 1'b0;
    logic         recent_reset;
    logic         wr_req_i;
    logic [10:0]  wr_x_i;
    logic [10:0]  wr_y_i;
    pix565_t      wr_data_i;
    channel_sel_e chan_sel_i;
    logic [7:0]   thresh_lo_i;
    logic [7:0]   thresh_hi_i;
    view_mode_e   view_i;
    logic [10:0]  marker_x_i;
    logic [10:0]  marker_y_i;
    logic         judgment_ok_i;
    logic         wr_ack_o;
    logic         hsync_o;
    logic         vsync_o;
    logic         de_o;
    rgb888_t      rgb_o;

    pix565_t shadow [FS_W * V_ACTIVE / 4];           // Expected frame store contents
    int      err_count = 0;
    int      cycles    = 0;

    `include "tb_vectors.svh"

    display_top #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(2), .H_SYNC(H_SYNC), .H_BACK(2),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(2), .V_SYNC(V_SYNC), .V_BACK(2)
    ) UUT (.*);

    always #50 clk_pixel = ~clk_pixel;

    // Three frames per test, plus reset and the initial fill
    always @(posedge clk_pixel) begin
        cycles <= cycles + 1;
        if (cycles > (3 * N_TESTS + 2) * FRAME) begin
            $display("Timeout, the DUT did not finish within %0d cycles", cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("ERR %s got %h expected %h", name, got, want);
            err_count++;
        end
    endtask

    // Reference model of one displayed pixel
    function automatic rgb888_t expected_pixel(input int col, input int row, input int t);
        pix565_t    p;
        rgb888_t    cam;
        logic [7:0] chan;
        p   = shadow[(row / 4) * FS_W + col / 4];          // 4x upscale
        cam = {p[15:11], 3'b000, p[10:5], 2'b00, p[4:0], 3'b000};
        chan = (tab_ch[t] == CH_RED) ? cam[23:16]
             : (tab_ch[t] == CH_GREEN) ? cam[15:8] : cam[7:0];
        if (tab_view[t] == VIEW_MASK) begin
            return (chan > tab_lo[t] && chan <= tab_hi[t]) ? 24'hFFFFFF : 24'h000000;
        end else if (tab_view[t] == VIEW_OVERLAY) begin
            if (col < 2 || col >= H_ACTIVE - 2 || row < 2 || row >= V_ACTIVE - 2) begin
                return tab_ok[t] ? 24'h00FF00 : 24'hFF0000;
            end else if (col == tab_mx[t] || row == tab_my[t]) begin
                return 24'hFFFF00;                         // Crosshair
            end
        end
        return cam;
    endfunction

    // Four-phase write, ack follows each req edge after exactly one clock
    task automatic write_pixel(input int x, input int y, input pix565_t data);
        @(posedge clk_pixel);
        wr_req_i  <= 1'b1;
        wr_x_i    <= x;
        wr_y_i    <= y;
        wr_data_i <= data;
        @(negedge clk_pixel);
        check_value("wr_ack_o", wr_ack_o, 0);
        @(negedge clk_pixel);
        check_value("wr_ack_o", wr_ack_o, 1);
        @(posedge clk_pixel);
        wr_req_i <= 1'b0;
        @(negedge clk_pixel);
        check_value("wr_ack_o", wr_ack_o, 1);     // Release not seen yet
        @(negedge clk_pixel);
        check_value("wr_ack_o", wr_ack_o, 0);
    endtask

    // One output frame, pixels located by counting de_o in rows split by hsync_o
    task automatic check_frame(input int t);
        int col;
        int row;
        int hs_len;
        int vs_len;
        col    = 0;
        row    = 0;
        hs_len = 0;
        vs_len = 0;
        @(negedge clk_pixel);
        while (vsync_o) @(negedge clk_pixel);
        while (!vsync_o) @(negedge clk_pixel);
        while (vsync_o) begin
            vs_len++;
            @(negedge clk_pixel);
        end
        check_value("vsync_o cycles", vs_len, V_SYNC * H_TOTAL);
        while (!vsync_o) begin
            if (de_o) begin
                check_value("rgb_o", rgb_o, expected_pixel(col, row, t));
                col++;
            end
            if (hsync_o) begin
                hs_len++;
            end else if (hs_len != 0) begin
                check_value("hsync_o cycles", hs_len, H_SYNC);
                hs_len = 0;
            end
            if (hsync_o && col != 0) begin            // Row closes at its hsync
                check_value("de_o per line", col, H_ACTIVE);
                row++;
                col = 0;
            end
            @(negedge clk_pixel);
        end
        check_value("de_o lines", row, V_ACTIVE);
    endtask

    initial begin
        int      failed;
        int      errs_before;
        pix565_t data;
        failed = 0;
        void'($urandom(32'h5ffe_465d));
        recent_reset  = 1'b1;
        wr_req_i      = 1'b0;
        wr_x_i        = '0;
        wr_y_i        = '0;
        wr_data_i     = '0;
        chan_sel_i    = CH_RED;
        thresh_lo_i   = '0;
        thresh_hi_i   = '0;
        view_i        = VIEW_CAMERA;
        marker_x_i    = '0;
        marker_y_i    = '0;
        judgment_ok_i = 1'b0;
        repeat (8) @(posedge clk_pixel);
        recent_reset <= 1'b0;
        @(negedge clk_pixel);
        check_value("wr_ack_o", wr_ack_o, 0);
        check_value("de_o", de_o, 0);
        // Give every stored block a random pixel
        for (int i = 0; i < $size(shadow); i++) begin
            data = $urandom;
            write_pixel((i % FS_W) * 4, (i / FS_W) * 4, data);
            shadow[i] = data;
        end
        for (int t = 0; t < N_TESTS; t++) begin
            errs_before = err_count;
            data        = $urandom;
            write_pixel(tab_x[t], tab_y[t], data);
            if (tab_keep[t]) begin
                shadow[(tab_y[t] / 4) * FS_W + tab_x[t] / 4] = data;
            end
            @(posedge clk_pixel);
            chan_sel_i    <= tab_ch[t];               // Taken at the next frame start
            thresh_lo_i   <= tab_lo[t];
            thresh_hi_i   <= tab_hi[t];
            view_i        <= tab_view[t];
            marker_x_i    <= tab_mx[t];
            marker_y_i    <= tab_my[t];
            judgment_ok_i <= tab_ok[t];
            check_frame(t);
            if (err_count == errs_before) begin
                $display("Test %0d passed", t);
            end else begin
                $display("Test %0d failed with %0d mismatches", t, err_count - errs_before);
                failed++;
            end
        end
        $display("Tests %0d, failed %0d, mismatches %0d", N_TESTS, failed, err_count);
        if (err_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+verif
verilog/display_pkg.sv
verilog/video_timing.sv
verilog/frame_store.sv
verilog/pixel_mask.sv
verilog/overlay_mux.sv
verilog/display_top.sv
verif/tb_display_top.sv
